// ==== rename_pkg.sv ====
package rename_pkg;

    // Architectural register file
    localparam int REG_COUNT = 32;  // Registers x0..x31
    localparam int REG_WIDTH = 5;   // Bits in a register address

    // Reorder buffer sizing
    localparam int ROB_DEPTH = 32;  // Entries in flight at most
    localparam int TAG_WIDTH = 5;   // A tag is the ROB slot index

    // The count must also hold ROB_DEPTH itself when full
    localparam int COUNT_WIDTH = 6;

    // x0 reads as zero and is never renamed
    localparam logic [REG_WIDTH-1:0] ZERO_REG = '0;

    // Depth and tag width are tied together, so the tag wraps on its own
    // at the end of the buffer and no compare against ROB_DEPTH-1 is needed

endpackage

// ==== rename_if_pkg.sv ====
package rename_if_pkg;

    // Register addresses of one instruction at dispatch
    typedef struct packed {
        logic [rename_pkg::REG_WIDTH-1:0] rs1;  // Source operand 1
        logic [rename_pkg::REG_WIDTH-1:0] rs2;  // Source operand 2
        logic [rename_pkg::REG_WIDTH-1:0] rd;   // Destination
    } dispatch_req_t;

    // Rename result for one source operand
    typedef struct packed {
        logic                             busy;   // Producer still in flight
        logic                             ready;  // Producer value sits in the ROB
        logic [rename_pkg::TAG_WIDTH-1:0] tag;    // ROB slot of the producer
    } operand_tag_t;

    // Completion broadcast on the common data bus
    typedef struct packed {
        logic                             valid;
        logic [rename_pkg::TAG_WIDTH-1:0] tag;    // Slot that just completed
    } cdb_t;

    // Head of the ROB leaving the machine
    typedef struct packed {
        logic [rename_pkg::REG_WIDTH-1:0] rd;     // Architectural destination
        logic [rename_pkg::TAG_WIDTH-1:0] tag;    // Slot being freed
    } retire_t;

endpackage

// ==== map_table.sv ====
`timescale 1ns/1ps

module map_table (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                dispatch_fire,
    input  rename_if_pkg::dispatch_req_t        dispatch_req,
    input  logic [rename_pkg::TAG_WIDTH-1:0]    alloc_tag,
    input  rename_if_pkg::cdb_t                 cdb,
    input  logic                                retire_fire,
    input  rename_if_pkg::retire_t              retire,
    output rename_if_pkg::operand_tag_t         rs1_operand,
    output rename_if_pkg::operand_tag_t         rs2_operand
);

    logic                             busy  [rename_pkg::REG_COUNT];  // Newest producer in flight
    logic                             ready [rename_pkg::REG_COUNT];  // That producer has completed
    logic [rename_pkg::TAG_WIDTH-1:0] tags  [rename_pkg::REG_COUNT];  // ROB slot of newest producer

    logic rename_dest;  // Dispatch writes a real destination

    assign rename_dest = dispatch_fire && (dispatch_req.rd != rename_pkg::ZERO_REG);

    // Source lookup against the state before this cycle's destination write.
    // A CDB hit in the same cycle is folded in so the operand is not left waiting.
    function automatic rename_if_pkg::operand_tag_t lookup(
        input logic [rename_pkg::REG_WIDTH-1:0] addr
    );
        rename_if_pkg::operand_tag_t result;
        result = '0;
        if (addr != rename_pkg::ZERO_REG && busy[addr]) begin
            result.busy  = 1'b1;
            result.tag   = tags[addr];
            result.ready = ready[addr] || (cdb.valid && cdb.tag == tags[addr]);  // Bypass
        end
        return result;
    endfunction

    always_comb begin
        rs1_operand = lookup(dispatch_req.rs1);
        rs2_operand = lookup(dispatch_req.rs2);
    end

    // Busy and ready bits. Later assignments win, so the order below gives
    // dispatch priority over retire, and retire over the CDB set.
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < rename_pkg::REG_COUNT; i++) begin
                busy[i]  <= 1'b0;
                ready[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < rename_pkg::REG_COUNT; i++) begin
                // CAM match on the broadcast tag
                if (cdb.valid && busy[i] && tags[i] == cdb.tag) begin
                    ready[i] <= 1'b1;
                end

                // Only clear if no newer rename took the register over
                if (retire_fire && retire.rd == rename_pkg::REG_WIDTH'(i)
                        && busy[i] && tags[i] == retire.tag) begin
                    busy[i]  <= 1'b0;
                    ready[i] <= 1'b0;
                end

                if (rename_dest && dispatch_req.rd == rename_pkg::REG_WIDTH'(i)) begin
                    busy[i]  <= 1'b1;
                    ready[i] <= 1'b0;  // New producer not done yet
                end
            end
        end
    end

    // Destination rename records the producer tag
    always_ff @(posedge clock) begin
        if (rename_dest) begin
            tags[dispatch_req.rd] <= alloc_tag;
        end
    end

endmodule

// ==== rob.sv ====
`timescale 1ns/1ps

module rob (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                dispatch_valid,
    input  logic [rename_pkg::REG_WIDTH-1:0]    dispatch_rd,
    output logic                                dispatch_ready,
    output logic [rename_pkg::TAG_WIDTH-1:0]    alloc_tag,
    input  rename_if_pkg::cdb_t                 cdb,
    output logic                                retire_valid,
    output rename_if_pkg::retire_t              retire,
    input  logic                                retire_ready
);

    logic [rename_pkg::TAG_WIDTH-1:0]   head;   // Oldest instruction
    logic [rename_pkg::TAG_WIDTH-1:0]   tail;   // Next slot to hand out
    logic [rename_pkg::COUNT_WIDTH-1:0] count;  // Entries in flight

    logic [rename_pkg::REG_WIDTH-1:0] rd_mem [rename_pkg::ROB_DEPTH];  // Destination per slot
    logic                             done   [rename_pkg::ROB_DEPTH];  // Completed via CDB

    logic alloc;      // Dispatch transfer this cycle
    logic dealloc;    // Retire transfer this cycle
    logic full;
    logic empty;

    assign full  = (count == rename_pkg::COUNT_WIDTH'(rename_pkg::ROB_DEPTH));
    assign empty = (count == '0);

    assign dispatch_ready = !full;
    assign alloc_tag      = tail;  // Tag is simply the tail slot
    assign alloc          = dispatch_valid && dispatch_ready;

    // Head is offered only once its result has been broadcast
    assign retire_valid = !empty && done[head];
    assign retire.rd    = rd_mem[head];
    assign retire.tag   = head;
    assign dealloc      = retire_valid && retire_ready;

    // Pointers wrap by overflow since depth is a power of two
    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (alloc) begin
                tail <= tail + 1'b1;
            end
            if (dealloc) begin
                head <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
        end else begin
            case ({alloc, dealloc})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

    // Completion bits. A fresh allocation starts not done.
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < rename_pkg::ROB_DEPTH; i++) begin
                done[i] <= 1'b0;
            end
        end else begin
            if (cdb.valid) begin
                done[cdb.tag] <= 1'b1;
            end
            if (alloc) begin
                done[tail] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (alloc) begin
            rd_mem[tail] <= dispatch_rd;
        end
    end

endmodule

// ==== rename_unit.sv ====
`timescale 1ns/1ps

module rename_unit (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                dispatch_valid,
    input  rename_if_pkg::dispatch_req_t        dispatch_req,
    output logic                                dispatch_ready,
    output logic [rename_pkg::TAG_WIDTH-1:0]    dispatch_tag,
    output rename_if_pkg::operand_tag_t         rs1_operand,
    output rename_if_pkg::operand_tag_t         rs2_operand,
    input  rename_if_pkg::cdb_t                 cdb,
    output logic                                retire_valid,
    output rename_if_pkg::retire_t              retire,
    input  logic                                retire_ready
);

    logic                             dispatch_fire;  // Handshake on dispatch
    logic                             retire_fire;    // Handshake on retire
    logic [rename_pkg::TAG_WIDTH-1:0] alloc_tag;      // Tag from ROB tail

    assign dispatch_fire = dispatch_valid & dispatch_ready;
    assign retire_fire   = retire_valid & retire_ready;
    assign dispatch_tag  = alloc_tag;

    map_table map_table_i (
        .clock         (clock),
        .reset         (reset),
        .dispatch_fire (dispatch_fire),
        .dispatch_req  (dispatch_req),
        .alloc_tag     (alloc_tag),
        .cdb           (cdb),
        .retire_fire   (retire_fire),
        .retire        (retire),
        .rs1_operand   (rs1_operand),
        .rs2_operand   (rs2_operand)
    );

    rob rob_i (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_rd    (dispatch_req.rd),
        .dispatch_ready (dispatch_ready),
        .alloc_tag      (alloc_tag),
        .cdb            (cdb),
        .retire_valid   (retire_valid),
        .retire         (retire),
        .retire_ready   (retire_ready)
    );

endmodule

// ==== tb_rename.sv ====
`timescale 1ns/1ps

module tb_rename;

    localparam int CLOCK_PERIOD  = 4;     // ns
    localparam int RESET_CYCLES  = 10;
    localparam int RANDOM_CYCLES = 800;   // Per random phase
    localparam int RUN_CYCLES    = 2000;  // Bound on reset, both random phases, fill and drain
    localparam int MARGIN_CYCLES = 200;

    logic                             clock = 1'b0;
    logic                             reset;
    logic                             dispatch_valid;
    rename_if_pkg::dispatch_req_t     dispatch_req;
    logic                             dispatch_ready;
    logic [rename_pkg::TAG_WIDTH-1:0] dispatch_tag;
    rename_if_pkg::operand_tag_t      rs1_operand;
    rename_if_pkg::operand_tag_t      rs2_operand;
    rename_if_pkg::cdb_t              cdb;
    logic                             retire_valid;
    rename_if_pkg::retire_t           retire;
    logic                             retire_ready;

    // Reference model state
    logic                             model_busy  [rename_pkg::REG_COUNT];
    logic                             model_ready [rename_pkg::REG_COUNT];
    logic [rename_pkg::TAG_WIDTH-1:0] model_tag   [rename_pkg::REG_COUNT];
    logic                             model_done  [rename_pkg::ROB_DEPTH];  // Indexed by tag
    logic [rename_pkg::REG_WIDTH-1:0] q_rd  [$];  // In-flight entries with the oldest first
    logic [rename_pkg::TAG_WIDTH-1:0] q_tag [$];
    logic [rename_pkg::TAG_WIDTH-1:0] next_tag;

    int  bypass_hits   = 0;
    int  stale_retires = 0;  // Retired tag no longer in the map
    int  retired_count = 0;
    int  zero_writes   = 0;
    logic saw_full     = 1'b0;

    rename_unit dut_i (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_req   (dispatch_req),
        .dispatch_ready (dispatch_ready),
        .dispatch_tag   (dispatch_tag),
        .rs1_operand    (rs1_operand),
        .rs2_operand    (rs2_operand),
        .cdb            (cdb),
        .retire_valid   (retire_valid),
        .retire         (retire),
        .retire_ready   (retire_ready)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("ERROR at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    function automatic logic [rename_pkg::REG_WIDTH-1:0] pick_reg();
        if ($urandom_range(0, 9) == 0) begin
            return rename_pkg::REG_WIDTH'($urandom_range(0, rename_pkg::REG_COUNT - 1));
        end
        return rename_pkg::REG_WIDTH'($urandom_range(0, 7));  // Small set gives many hazards
    endfunction

    function automatic rename_if_pkg::dispatch_req_t random_req();
        rename_if_pkg::dispatch_req_t req;
        req.rs1 = pick_reg();
        req.rs2 = pick_reg();
        req.rd  = pick_reg();
        return req;
    endfunction

    function automatic int undone_count();
        int n;
        n = 0;
        foreach (q_tag[i]) begin
            if (!model_done[q_tag[i]]) n++;
        end
        return n;
    endfunction

    // Broadcast one in-flight tag that has not completed, chosen at random
    task automatic send_cdb(input logic enable);
        logic [rename_pkg::TAG_WIDTH-1:0] candidates [$];
        int pick;
        foreach (q_tag[i]) begin
            if (!model_done[q_tag[i]]) candidates.push_back(q_tag[i]);
        end
        cdb = '0;
        if (enable && candidates.size() > 0) begin
            pick      = int'($urandom_range(0, candidates.size() - 1));
            cdb.valid = 1'b1;
            cdb.tag   = candidates[pick];
        end
    endtask

    task automatic drive_random();
        dispatch_valid = ($urandom_range(0, 99) < 40);
        dispatch_req   = random_req();
        retire_ready   = ($urandom_range(0, 99) < 60);
        send_cdb($urandom_range(0, 99) < 50);
    endtask

    function automatic rename_if_pkg::operand_tag_t expected_operand(
        input logic [rename_pkg::REG_WIDTH-1:0] addr
    );
        rename_if_pkg::operand_tag_t op;
        op = '0;
        if (addr != rename_pkg::ZERO_REG && model_busy[addr]) begin
            op.busy  = 1'b1;
            op.tag   = model_tag[addr];
            op.ready = model_ready[addr] || (cdb.valid && cdb.tag == model_tag[addr]);
        end
        return op;
    endfunction

    task automatic check_outputs();
        rename_if_pkg::operand_tag_t exp_rs1;
        rename_if_pkg::operand_tag_t exp_rs2;
        logic exp_retire_valid;
        exp_retire_valid = 1'b0;
        if (q_tag.size() > 0) exp_retire_valid = model_done[q_tag[0]];
        check_value("dispatch_ready", 32'(q_tag.size() < rename_pkg::ROB_DEPTH),
                    32'(dispatch_ready));
        check_value("dispatch_tag", 32'(next_tag), 32'(dispatch_tag));
        check_value("retire_valid", 32'(exp_retire_valid), 32'(retire_valid));
        if (exp_retire_valid) begin
            check_value("retire.rd", 32'(q_rd[0]), 32'(retire.rd));
            check_value("retire.tag", 32'(q_tag[0]), 32'(retire.tag));
        end
        if (dispatch_valid) begin  // Operands only mean something on dispatch
            exp_rs1 = expected_operand(dispatch_req.rs1);
            exp_rs2 = expected_operand(dispatch_req.rs2);
            check_value("rs1_operand", 32'(exp_rs1), 32'(rs1_operand));
            check_value("rs2_operand", 32'(exp_rs2), 32'(rs2_operand));
            if (exp_rs1.ready && !model_ready[dispatch_req.rs1]) bypass_hits++;
            if (exp_rs2.ready && !model_ready[dispatch_req.rs2]) bypass_hits++;
        end
    endtask

    // Applied in hardware priority order of CDB, then retire, then dispatch
    task automatic update_model();
        logic fire_dispatch;
        logic fire_retire;
        logic [rename_pkg::REG_WIDTH-1:0] r_rd;
        logic [rename_pkg::TAG_WIDTH-1:0] r_tag;
        fire_dispatch = dispatch_valid && (q_tag.size() < rename_pkg::ROB_DEPTH);
        fire_retire   = 1'b0;
        if (q_tag.size() > 0) fire_retire = model_done[q_tag[0]] && retire_ready;
        if (cdb.valid) begin
            model_done[cdb.tag] = 1'b1;
            for (int i = 0; i < rename_pkg::REG_COUNT; i++) begin
                if (model_busy[i] && model_tag[i] == cdb.tag) model_ready[i] = 1'b1;
            end
        end
        if (fire_retire) begin
            r_rd  = q_rd.pop_front();
            r_tag = q_tag.pop_front();
            retired_count++;
            if (model_busy[r_rd] && model_tag[r_rd] == r_tag) begin
                model_busy[r_rd]  = 1'b0;
                model_ready[r_rd] = 1'b0;
            end else if (model_busy[r_rd]) begin
                stale_retires++;  // Renamed again since
            end
        end
        if (fire_dispatch) begin
            q_rd.push_back(dispatch_req.rd);
            q_tag.push_back(next_tag);
            model_done[next_tag] = 1'b0;
            if (dispatch_req.rd != rename_pkg::ZERO_REG) begin
                model_busy[dispatch_req.rd]  = 1'b1;
                model_ready[dispatch_req.rd] = 1'b0;
                model_tag[dispatch_req.rd]   = next_tag;
            end else begin
                zero_writes++;
            end
            next_tag = next_tag + 1'b1;  // Wraps at ROB_DEPTH
        end
        if (q_tag.size() == rename_pkg::ROB_DEPTH) saw_full = 1'b1;
    endtask

    always @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < rename_pkg::REG_COUNT; i++) begin
                model_busy[i]  = 1'b0;
                model_ready[i] = 1'b0;
                model_tag[i]   = '0;
            end
            for (int i = 0; i < rename_pkg::ROB_DEPTH; i++) model_done[i] = 1'b0;
            q_rd.delete();
            q_tag.delete();
            next_tag = '0;
        end else begin
            check_outputs();
            update_model();
        end
    end

    initial begin
        void'($urandom(22));
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_req   = '0;
        cdb            = '0;
        retire_ready   = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        repeat (RANDOM_CYCLES) begin
            drive_random();
            @(negedge clock);
        end

        // Fill the ROB with retirement held off, then push against full
        cdb            = '0;
        retire_ready   = 1'b0;
        dispatch_valid = 1'b1;
        while (dispatch_ready) begin
            dispatch_req = random_req();
            @(negedge clock);
        end
        repeat (3) begin
            dispatch_req = random_req();
            @(negedge clock);
        end

        // Complete everything, retire one, then dispatch into the freed slot
        dispatch_valid = 1'b0;
        while (undone_count() > 0) begin
            send_cdb(1'b1);
            @(negedge clock);
        end
        cdb = '0;
        while (!retire_valid) @(negedge clock);
        retire_ready = 1'b1;
        @(negedge clock);
        retire_ready   = 1'b0;
        dispatch_valid = 1'b1;
        dispatch_req   = random_req();
        @(negedge clock);

        repeat (RANDOM_CYCLES) begin
            drive_random();
            @(negedge clock);
        end

        if (saw_full && bypass_hits > 0 && stale_retires > 0 && retired_count > 0
                && zero_writes > 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Stimulus did not reach every behavior");
            $display("full %0d bypass %0d stale %0d retired %0d x0 %0d",
                     saw_full, bypass_hits, stale_retires, retired_count, zero_writes);
            $display("Errors found");
            $fatal(1);
        end
    end

    // Watchdog
    initial begin
        #(CLOCK_PERIOD * (RUN_CYCLES + MARGIN_CYCLES));
        $display("Timeout: the run did not end within %0d cycles", RUN_CYCLES + MARGIN_CYCLES);
        $display("Errors found");
        $fatal(1);
    end

endmodule

// ==== all.f ====
rename_pkg.sv
rename_if_pkg.sv
map_table.sv
rob.sv
rename_unit.sv
tb_rename.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the rename unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -f all.f --top-module tb_rename -o sim_rename
if [ $? -ne 0 ]; then
    echo "Compile failed"
    exit 1
fi

./obj_dir/sim_rename > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^No errors$" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
